// ==== Bender.yml ====
package:
  name: rv_core

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/rvPkg.sv
      - logic/rvRegFile.sv
      - logic/rvAlu.sv
      - logic/rvControl.sv
      - logic/rvDatapath.sv
      - logic/rvCore.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - tb/rvCore_asserts.sv
      - tb/rvCoreTb.sv

// ==== compile.f ====
+incdir+logic
logic/rvPkg.sv
logic/rvRegFile.sv
logic/rvAlu.sv
logic/rvControl.sv
logic/rvDatapath.sv
logic/rvCore.sv
tb/rvCore_asserts.sv
tb/rvCoreTb.sv

// ==== logic/rvAlu.sv ====
`timescale 1ns/1ps
`include "rv_config.svh"

module rvAlu (
	input  logic [`XLEN-1:0] opA,
	input  logic [`XLEN-1:0] opB,
	input  rvPkg::aluOpT     aluOp,
	output logic [`XLEN-1:0] result,
	output logic             zero
);
	import rvPkg::*;

	always_comb begin
		case (aluOp)
			aluAdd: result = opA + opB;
			aluSub: result = opA - opB; // Also the branch compare
			aluAnd: result = opA & opB;
			aluOr:  result = opA | opB;
			aluXor: result = opA ^ opB;
			default: result = opA + opB;
		endcase
	end

	assign zero = (result == '0);

endmodule

// ==== logic/rvControl.sv ====
`timescale 1ns/1ps

module rvControl (
	input  logic          CLK,
	input  logic          RSTn,
	input  rvPkg::opcodeT opcode,
	input  logic [2:0]    funct3,
	input  logic          funct7b5,
	input  logic          pready,
	output logic          irWrite,
	output logic          pcWrite,
	output logic          pcWriteCond,
	output logic          branchNe,
	output logic          rfWrite,
	output logic          wbFromMem,
	output logic          apbLatch,
	output logic          psel,
	output logic          penable,
	output logic          pwrite,
	output rvPkg::srcAT   srcA,
	output rvPkg::srcBT   srcB,
	output rvPkg::aluOpT  aluOp,
	output logic [31:0]   instRetired
);
	import rvPkg::*;

	ctrlStateT state;
	ctrlStateT nextState;
	aluOpT     funcOp;
	logic      apbNext;

	// ALU operation of register and immediate instructions
	always_comb begin
		case (funct3)
			3'b000: funcOp = (opcode == opReg && funct7b5) ? aluSub : aluAdd;
			3'b100: funcOp = aluXor;
			3'b110: funcOp = aluOr;
			3'b111: funcOp = aluAnd;
			default: funcOp = aluAdd;
		endcase
	end

	always_comb begin
		irWrite     = 1'b0;
		pcWrite     = 1'b0;
		pcWriteCond = 1'b0;
		branchNe    = 1'b0;
		rfWrite     = 1'b0;
		wbFromMem   = 1'b0;
		apbLatch    = 1'b0;
		srcA        = srcRs1; // Keeps the ALU register steady
		srcB        = srcImm;
		aluOp       = aluAdd;
		nextState   = state;
		case (state)
			stFetch: begin
				irWrite   = 1'b1;
				pcWrite   = 1'b1;
				srcA      = srcPc;
				srcB      = srcFour;
				nextState = stDecode;
			end
			stDecode: begin
				// Link address for jumps, branch target otherwise
				srcA = srcOldPc;
				srcB = (opcode == opJal || opcode == opJalr) ? srcFour : srcImm;
				case (opcode)
					opLoad, opStore: nextState = stAddrCalc;
					opImm, opReg:    nextState = stRegExec;
					opBranch:        nextState = stBranchCmp;
					opJal:           nextState = stJalLink;
					opJalr:          nextState = stJalrTarget;
					default:         nextState = stFetch; // Unknown opcode retires as no-op
				endcase
			end
			stJalLink: begin
				srcA      = srcOldPc;
				pcWrite   = 1'b1;
				rfWrite   = 1'b1;
				nextState = stFetch;
			end
			stJalrTarget: begin
				pcWrite   = 1'b1;
				rfWrite   = 1'b1;
				nextState = stFetch;
			end
			stAddrCalc: begin
				apbLatch  = 1'b1; // Address and store data into APB registers
				nextState = stApbSetup;
			end
			stApbSetup: nextState = stApbAccess;
			stApbAccess: begin
				if (pready) begin
					if (opcode == opLoad) begin
						wbFromMem = 1'b1; // Capture read data
						nextState = stLoadWb;
					end else begin
						nextState = stFetch;
					end
				end
			end
			stLoadWb: begin
				rfWrite   = 1'b1;
				wbFromMem = 1'b1;
				nextState = stFetch;
			end
			stRegExec: begin
				srcB      = (opcode == opReg) ? srcRs2 : srcImm;
				aluOp     = funcOp;
				nextState = stAluWb;
			end
			stAluWb: begin
				rfWrite   = 1'b1;
				nextState = stFetch;
			end
			stBranchCmp: begin
				srcB        = srcRs2;
				aluOp       = aluSub;
				pcWriteCond = 1'b1;
				branchNe    = funct3[0];
				nextState   = stFetch;
			end
			default: nextState = stFetch;
		endcase
	end

	assign apbNext = (nextState == stApbSetup) || (nextState == stApbAccess);

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			state       <= stFetch;
			psel        <= 1'b0;
			penable     <= 1'b0;
			pwrite      <= 1'b0;
			instRetired <= '0;
		end else begin
			state   <= nextState;
			psel    <= apbNext;
			penable <= (nextState == stApbAccess);
			pwrite  <= apbNext && (opcode == opStore);
			if (nextState == stFetch) begin
				instRetired <= instRetired + 32'd1; // One per completed instruction
			end
		end
	end

endmodule

// ==== logic/rvCore.sv ====
`timescale 1ns/1ps
`include "rv_config.svh"

module rvCore (
	input  logic             CLK,
	input  logic             RSTn,
	output logic [`XLEN-1:0] instrAddr,
	input  logic [`XLEN-1:0] instrData,
	output logic [`XLEN-1:0] paddr,
	output logic             psel,
	output logic             penable,
	output logic             pwrite,
	output logic [`XLEN-1:0] pwdata,
	input  logic [`XLEN-1:0] prdata,
	input  logic             pready,
	output logic [31:0]      instRetired
);
	import rvPkg::*;

	opcodeT           opcode;
	logic [2:0]       funct3;
	logic             funct7b5;
	logic             irWrite;
	logic             pcWrite;
	logic             pcWriteCond;
	logic             branchNe;
	logic             rfWrite;
	logic             wbFromMem;
	logic             apbLatch;
	srcAT             srcA;
	srcBT             srcB;
	aluOpT            aluOp;
	logic [`XLEN-1:0] opA;
	logic [`XLEN-1:0] opB;
	logic [`XLEN-1:0] aluResult;
	logic             aluZero;

	rvControl i_control (
		.CLK         (CLK),
		.RSTn        (RSTn),
		.opcode      (opcode),
		.funct3      (funct3),
		.funct7b5    (funct7b5),
		.pready      (pready),
		.irWrite     (irWrite),
		.pcWrite     (pcWrite),
		.pcWriteCond (pcWriteCond),
		.branchNe    (branchNe),
		.rfWrite     (rfWrite),
		.wbFromMem   (wbFromMem),
		.apbLatch    (apbLatch),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.srcA        (srcA),
		.srcB        (srcB),
		.aluOp       (aluOp),
		.instRetired (instRetired)
	);

	rvDatapath i_datapath (
		.CLK         (CLK),
		.RSTn        (RSTn),
		.irWrite     (irWrite),
		.pcWrite     (pcWrite),
		.pcWriteCond (pcWriteCond),
		.branchNe    (branchNe),
		.rfWrite     (rfWrite),
		.wbFromMem   (wbFromMem),
		.srcA        (srcA),
		.srcB        (srcB),
		.apbLatch    (apbLatch),
		.aluResult   (aluResult),
		.aluZero     (aluZero),
		.instrData   (instrData),
		.prdata      (prdata),
		.instrAddr   (instrAddr),
		.paddr       (paddr),
		.pwdata      (pwdata),
		.opA         (opA),
		.opB         (opB),
		.opcode      (opcode),
		.funct3      (funct3),
		.funct7b5    (funct7b5)
	);

	rvAlu i_alu (
		.opA    (opA),
		.opB    (opB),
		.aluOp  (aluOp),
		.result (aluResult),
		.zero   (aluZero)
	);

endmodule

// ==== logic/rvDatapath.sv ====
`timescale 1ns/1ps
`include "rv_config.svh"

module rvDatapath (
	input  logic             CLK,
	input  logic             RSTn,
	input  logic             irWrite,
	input  logic             pcWrite,
	input  logic             pcWriteCond,
	input  logic             branchNe,
	input  logic             rfWrite,
	input  logic             wbFromMem,
	input  rvPkg::srcAT      srcA,
	input  rvPkg::srcBT      srcB,
	input  logic             apbLatch,
	input  logic [`XLEN-1:0] aluResult,
	input  logic             aluZero,
	input  logic [`XLEN-1:0] instrData,
	input  logic [`XLEN-1:0] prdata,
	output logic [`XLEN-1:0] instrAddr,
	output logic [`XLEN-1:0] paddr,
	output logic [`XLEN-1:0] pwdata,
	output logic [`XLEN-1:0] opA,
	output logic [`XLEN-1:0] opB,
	output rvPkg::opcodeT    opcode,
	output logic [2:0]       funct3,
	output logic             funct7b5
);
	import rvPkg::*;

	logic [`XLEN-1:0] pc;
	logic [`XLEN-1:0] oldPc;
	logic [`XLEN-1:0] ir;
	logic [`XLEN-1:0] rs1Q;
	logic [`XLEN-1:0] rs2Q;
	logic [`XLEN-1:0] aluOut;
	logic [`XLEN-1:0] mdr;
	logic [`XLEN-1:0] imm;
	logic [`XLEN-1:0] pcNext;
	logic [`XLEN-1:0] rs1Data;
	logic [`XLEN-1:0] rs2Data;
	logic [`XLEN-1:0] rdData;
	logic             taken;

	assign opcode   = opcodeT'(ir[6:0]);
	assign funct3   = ir[14:12];
	assign funct7b5 = ir[30];

	always_comb begin
		case (opcode)
			opStore:  imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
			opBranch: imm = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
			opJal:    imm = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
			default:  imm = {{20{ir[31]}}, ir[31:20]};
		endcase
	end

	always_comb begin
		case (srcA)
			srcPc:    opA = pc;
			srcOldPc: opA = oldPc;
			default:  opA = rs1Q;
		endcase
		case (srcB)
			srcRs2:  opB = rs2Q;
			srcFour: opB = `XLEN'(4);
			default: opB = imm;
		endcase
	end

	// Branch target sits in aluOut since decode
	assign taken  = pcWriteCond && (aluZero ^ branchNe);
	assign pcNext = pcWriteCond ? aluOut : aluResult;

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			pc <= `RESET_PC;
		end else if (pcWrite || taken) begin
			pc <= {pcNext[`XLEN-1:1], 1'b0}; // JALR clears bit 0
		end
	end

	always_ff @(posedge CLK) begin
		if (irWrite) begin
			ir    <= instrData;
			oldPc <= pc;
		end
		rs1Q   <= rs1Data;
		rs2Q   <= rs2Data;
		aluOut <= aluResult;
		if (wbFromMem && !rfWrite) begin
			mdr <= prdata; // Completing read access
		end
		if (apbLatch) begin
			paddr  <= aluResult;
			pwdata <= rs2Q;
		end
	end

	assign rdData    = wbFromMem ? mdr : aluOut;
	assign instrAddr = pc;

	rvRegFile i_regFile (
		.CLK     (CLK),
		.RSTn    (RSTn),
		.rs1Addr (ir[19:15]),
		.rs2Addr (ir[24:20]),
		.rdAddr  (ir[11:7]),
		.rdData  (rdData),
		.writeEn (rfWrite),
		.rs1Data (rs1Data),
		.rs2Data (rs2Data)
	);

endmodule

// ==== logic/rvPkg.sv ====
package rvPkg;

	typedef enum logic [6:0] {
		opLoad   = 7'b0000011,
		opStore  = 7'b0100011,
		opImm    = 7'b0010011,
		opReg    = 7'b0110011,
		opBranch = 7'b1100011,
		opJal    = 7'b1101111,
		opJalr   = 7'b1100111
	} opcodeT;

	typedef enum logic [3:0] {
		stFetch,
		stDecode,
		stJalLink,
		stJalrTarget,
		stAddrCalc,
		stRegExec,
		stBranchCmp,
		stBranchDone,
		stApbSetup,
		stApbAccess,
		stLoadWb,
		stAluWb
	} ctrlStateT;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor
	} aluOpT;

	typedef enum logic [1:0] {
		srcPc,
		srcOldPc,
		srcRs1
	} srcAT;

	typedef enum logic [1:0] {
		srcRs2,
		srcImm,
		srcFour
	} srcBT;

endpackage

// ==== logic/rvRegFile.sv ====
`timescale 1ns/1ps
`include "rv_config.svh"

module rvRegFile (
	input  logic                             CLK,
	input  logic                             RSTn,
	input  logic [$clog2(`REG_COUNT)-1:0]    rs1Addr,
	input  logic [$clog2(`REG_COUNT)-1:0]    rs2Addr,
	input  logic [$clog2(`REG_COUNT)-1:0]    rdAddr,
	input  logic [`XLEN-1:0]                 rdData,
	input  logic                             writeEn,
	output logic [`XLEN-1:0]                 rs1Data,
	output logic [`XLEN-1:0]                 rs2Data
);

	logic [`XLEN-1:0] regs [`REG_COUNT];

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn && rdAddr != '0) begin
			regs[rdAddr] <= rdData; // x0 never written
		end
	end

	assign rs1Data = (rs1Addr == '0) ? '0 : regs[rs1Addr];
	assign rs2Data = (rs2Addr == '0) ? '0 : regs[rs2Addr];

endmodule

// ==== logic/rv_config.svh ====
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// Data and address width
`define XLEN 32

// Architectural integer registers
`define REG_COUNT 32

// First fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

// ==== tb/rvCoreTb.sv ====
`timescale 1ns/1ps
`include "rv_config.svh"

module rvCoreTb;

	localparam int     NUM_INSTR        = 2000;
	localparam int     MAX_INSTR_CYCLES = 9; // LW with three wait cycles
	localparam int     CLK_PERIOD       = 20;
	localparam int     RESET_CYCLES     = 16;
	localparam longint WATCHDOG_NS      =
		longint'(NUM_INSTR) * MAX_INSTR_CYCLES * CLK_PERIOD * 2;

	logic             CLK = 1'b0;
	logic             RSTn;
	logic [`XLEN-1:0] instrAddr;
	logic [`XLEN-1:0] instrData;
	logic [`XLEN-1:0] paddr;
	logic             psel;
	logic             penable;
	logic             pwrite;
	logic [`XLEN-1:0] pwdata;
	logic [`XLEN-1:0] prdata;
	logic             pready;
	logic [31:0]      instRetired;

	logic [31:0] lfsrState;
	logic [31:0] imem [256];
	logic [31:0] dmem [256];
	logic [31:0] refMem [256];
	logic [31:0] refRegs [32];
	logic [31:0] modelPc;
	logic [31:0] seenRetired;
	int          modelCount;
	int          waitLeft;
	logic        xferSeen; // Last APB transfer, as seen by the responder
	logic        xferWrite;
	logic [31:0] xferAddr;
	logic [31:0] xferData;
	int          checks;
	int          errors;

	always #10 CLK = ~CLK;

	assign instrData = imem[instrAddr[9:2]];

	rvCore i_dut (
		.CLK         (CLK),
		.RSTn        (RSTn),
		.instrAddr   (instrAddr),
		.instrData   (instrData),
		.paddr       (paddr),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.pwdata      (pwdata),
		.prdata      (prdata),
		.pready      (pready),
		.instRetired (instRetired)
	);

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] randBits(input int width);
		logic [31:0] value;
		logic        fb;
		value = '0;
		for (int i = 0; i < width; i++) begin
			fb        = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
			lfsrState = {lfsrState[30:0], fb};
			value     = {value[30:0], fb};
		end
		return value;
	endfunction

	function automatic logic [31:0] makeInstr();
		logic [3:0]  kind;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [11:0] imm;
		logic [12:0] off;
		logic [2:0]  f3;
		logic        flag;
		kind = randBits(4);
		rd   = randBits(3); // x0..x7 only, for more dependencies
		rs1  = randBits(3);
		rs2  = randBits(3);
		imm  = randBits(12);
		off  = (randBits(4) + 1) << 2; // Forward only, so no tight loops
		flag = randBits(1);
		case (randBits(2))
			2'd0: f3 = 3'b000;
			2'd1: f3 = 3'b100;
			2'd2: f3 = 3'b110;
			default: f3 = 3'b111;
		endcase
		case (kind)
			4'd0, 4'd1, 4'd2, 4'd3: return {imm, rs1, f3, rd, 7'b0010011};
			4'd4, 4'd5, 4'd6: return {1'b0, flag & (f3 == 3'b000), 5'b0, rs2, rs1, f3, rd, 7'b0110011};
			4'd7, 4'd8: return {imm, rs1, 3'b010, rd, 7'b0000011};
			4'd9, 4'd10: return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
			4'd11, 4'd12: return {1'b0, off[10:5], rs2, rs1, 2'b00, flag, off[4:1], 1'b0, 7'b1100011};
			4'd13: return {1'b0, off[10:1], 1'b0, 8'b0, rd, 7'b1101111};
			4'd14: return {imm, rs1, 3'b000, rd, 7'b1100111};
			default: return {imm, rs1, 3'b000, rd, 7'b0001011}; // Unknown opcode
		endcase
	endfunction

	function automatic logic [31:0] aluModel(input logic [2:0] f3, input logic sub,
			input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'b000: return sub ? a - b : a + b;
			3'b100: return a ^ b;
			3'b110: return a | b;
			3'b111: return a & b;
			default: return a + b;
		endcase
	endfunction

	task automatic checkValue(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		checks++;
		assert (got === expected) else begin
			errors++;
			$display("CHECK FAILED %s: got %h expected %h", name, got, expected);
		end
	endtask

	task automatic checkTransfer(input logic isWrite, input logic [31:0] addr,
			input logic [31:0] data);
		checks++;
		assert (xferSeen) else begin
			errors++;
			$display("No APB transfer was seen for a load or store at pc %h", modelPc);
		end
		checkValue("pwrite", xferWrite, isWrite);
		checkValue("paddr", xferAddr, addr);
		if (isWrite) begin
			checkValue("pwdata", xferData, data);
		end
	endtask

	task automatic writeReg(input logic [4:0] rd, input logic [31:0] value);
		if (rd != 5'd0) begin
			refRegs[rd] = value;
		end
	endtask

	// Architectural model, one instruction per call
	task automatic stepModel();
		logic [31:0] ins;
		logic [31:0] r1;
		logic [31:0] r2;
		logic [31:0] immI;
		logic [31:0] immS;
		logic [31:0] immB;
		logic [31:0] immJ;
		logic [31:0] addr;
		logic [31:0] nextPc;
		ins    = imem[modelPc[9:2]];
		r1     = refRegs[ins[19:15]];
		r2     = refRegs[ins[24:20]];
		immI   = {{20{ins[31]}}, ins[31:20]};
		immS   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
		immB   = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
		immJ   = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
		nextPc = modelPc + 32'd4;
		case (ins[6:0])
			7'b0010011, 7'b0110011: begin
				// Bit 5 of the opcode selects rs2 over the immediate
				writeReg(ins[11:7], aluModel(ins[14:12], ins[5] & ins[30], r1, ins[5] ? r2 : immI));
			end
			7'b0000011: begin
				addr = r1 + immI;
				checkTransfer(1'b0, addr, 32'h0);
				writeReg(ins[11:7], refMem[addr[9:2]]);
			end
			7'b0100011: begin
				addr = r1 + immS;
				checkTransfer(1'b1, addr, r2);
				refMem[addr[9:2]] = r2;
			end
			7'b1100011: begin
				if ((r1 == r2) != ins[12]) begin
					nextPc = modelPc + immB;
				end
			end
			7'b1101111: begin
				writeReg(ins[11:7], modelPc + 32'd4);
				nextPc = modelPc + immJ;
			end
			7'b1100111: begin
				nextPc = (r1 + immI) & ~32'd1;
				writeReg(ins[11:7], modelPc + 32'd4);
			end
			default: ;
		endcase
		if (ins[6:0] != 7'b0000011 && ins[6:0] != 7'b0100011) begin
			checks++;
			assert (!xferSeen) else begin
				errors++;
				$display("APB transfer seen for an instruction that is not a load or store");
			end
		end
		xferSeen   = 1'b0;
		modelPc    = nextPc;
		modelCount = modelCount + 1;
	endtask

	// APB responder with 0 to 3 wait cycles
	always @(posedge CLK) begin
		#2;
		if (psel && !penable) begin
			waitLeft = randBits(2);
			pready   = 1'b0;
		end else if (psel && penable && waitLeft > 0) begin
			waitLeft--;
			pready = 1'b0;
		end else if (psel && penable) begin
			pready    = 1'b1;
			xferSeen  = 1'b1;
			xferWrite = pwrite;
			xferAddr  = paddr;
			xferData  = pwdata;
			if (pwrite) begin
				dmem[paddr[9:2]] = pwdata;
			end else begin
				prdata = dmem[paddr[9:2]];
			end
		end else begin
			pready = 1'b0;
		end
	end

	always @(posedge CLK) begin
		#2;
		if (!RSTn && instRetired !== seenRetired) begin
			seenRetired = instRetired;
			stepModel();
			checkValue("instrAddr", instrAddr, modelPc);
			checkValue("instRetired", instRetired, modelCount);
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns with %0d instructions retired",
			WATCHDOG_NS, modelCount);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		lfsrState   = 32'h16192137;
		RSTn        = 1'b1;
		prdata      = '0;
		pready      = 1'b0;
		waitLeft    = 0;
		xferSeen    = 1'b0;
		xferWrite   = 1'b0;
		xferAddr    = '0;
		xferData    = '0;
		checks      = 0;
		errors      = 0;
		modelCount  = 0;
		modelPc     = `RESET_PC;
		seenRetired = '0;
		for (int i = 0; i < 256; i++) begin
			imem[i] = makeInstr();
		end
		for (int i = 0; i < 256; i++) begin
			dmem[i]   = randBits(32);
			refMem[i] = dmem[i];
		end
		for (int i = 0; i < 32; i++) begin
			refRegs[i] = '0;
		end
		repeat (RESET_CYCLES) @(posedge CLK);
		#2;
		checkValue("instrAddr", instrAddr, `RESET_PC);
		checkValue("psel", psel, 32'h0);
		checkValue("instRetired", instRetired, 32'h0);
		RSTn = 1'b0;
		wait (modelCount >= NUM_INSTR);
		checkValue("instRetired", instRetired, modelCount);
		$display("Run complete: %0d instructions, %0d checks, %0d errors, %0d assertion failures",
			modelCount, checks, errors, i_dut.i_asserts.failCount);
		if (errors == 0 && i_dut.i_asserts.failCount == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// ==== tb/rvCore_asserts.sv ====
`timescale 1ns/1ps
`include "rv_config.svh"

module rvCoreAsserts (
	input logic             CLK,
	input logic             RSTn,
	input logic             psel,
	input logic             penable,
	input logic             pwrite,
	input logic             pready,
	input logic [`XLEN-1:0] paddr,
	input logic [`XLEN-1:0] pwdata,
	input logic             irWrite,
	input logic             pcWrite,
	input logic             pcWriteCond,
	input logic             rfWrite,
	input logic             apbLatch
);

	int failCount = 0; // Number of failed assertions

	apbSetupOneCycle: assert property (@(posedge CLK) disable iff (RSTn)
		psel && !penable |=> psel && penable)
		else begin
			failCount++;
			$error("APB setup phase did not last exactly one cycle");
		end

	// Request held steady through wait states
	apbStableWait: assert property (@(posedge CLK) disable iff (RSTn)
		psel && penable && !pready |=>
			psel && penable && $stable(paddr) && $stable(pwrite) && $stable(pwdata))
		else begin
			failCount++;
			$error("APB request changed or dropped before pready");
		end

	apbEndAfterReady: assert property (@(posedge CLK) disable iff (RSTn)
		psel && penable && pready |=> !psel && !penable)
		else begin
			failCount++;
			$error("APB psel or penable still high after the transfer ended");
		end

	strobesOneHot: assert property (@(posedge CLK) disable iff (RSTn)
		$onehot0({irWrite, pcWriteCond, rfWrite, apbLatch}) && !(pcWrite && pcWriteCond))
		else begin
			failCount++;
			$error("Control strobes of different states active together");
		end

endmodule

bind rvCore rvCoreAsserts i_asserts (
	.CLK         (CLK),
	.RSTn        (RSTn),
	.psel        (psel),
	.penable     (penable),
	.pwrite      (pwrite),
	.pready      (pready),
	.paddr       (paddr),
	.pwdata      (pwdata),
	.irWrite     (irWrite),
	.pcWrite     (pcWrite),
	.pcWriteCond (pcWriteCond),
	.rfWrite     (rfWrite),
	.apbLatch    (apbLatch)
);
